// ==== bench/pipeline_control_tb.sv ====
`timescale 1ns/1ps

module pipeline_control_tb;

    logic clk_i;
    logic reset_i;
    logic finish_test_i;
    logic ic_hit_i;
    logic valid_id_i;
    logic [ctrl_pkg::REG_SIZE-1:0] src_a_id_i;
    logic [ctrl_pkg::REG_SIZE-1:0] src_b_id_i;
    logic [ctrl_pkg::REG_SIZE-1:0] dst_id_i;
    logic rd_src_a_id_i;
    logic rd_src_b_id_i;
    logic we_id_i;
    logic mem_access_id_i;
    logic tkbr_i;
    logic dc_hit_i;
    logic store_buffer_draining_i;
    logic mem_done_i;

    logic block_if_o, block_id_o, block_ex_o, block_mem_o;
    logic inject_nops_id_o, inject_nops_ex_o, inject_nops_wb_o;
    logic blocked_1cycle_ago_if_o, blocked_1cycle_ago_mem_o;
    logic tkbr_o, finish_test_o, mem_req_o;
    logic valid_ex_o, valid_mem_o, valid_wb_o;
    ctrl_pkg::mem_owner_e sel_mem_req_o;

    // Reference state with EX at index 0, MEM at 1 and WB at 2
    logic                          m_valid [3];
    logic [ctrl_pkg::REG_SIZE-1:0] m_dst [3];
    logic                          m_we [3];
    logic                          m_ma [3];
    logic                          m_fin;
    int                            m_fin_age; // Edges since the latch
    logic                          m_prev_if;
    logic                          m_prev_mem;
    ctrl_pkg::arb_state_e          m_arb;

    logic [15:0] lfsr_state = 16'h0001;
    int error_count = 0;
    int check_count = 0;
    int tests_run = 0;
    int test_start_errors = 0;
    int random_cycles = 200;
    int directed_cycles = 120;
    int stall_cycles;

    string out_names [16] = '{"block_if_o", "block_id_o", "block_ex_o", "block_mem_o",
        "inject_nops_id_o", "inject_nops_ex_o", "inject_nops_wb_o", "blocked_1cycle_ago_if_o",
        "blocked_1cycle_ago_mem_o", "tkbr_o", "finish_test_o", "sel_mem_req_o", "mem_req_o",
        "valid_ex_o", "valid_mem_o", "valid_wb_o"};

    pipeline_control DUT (.*);

    always #2 clk_i = ~clk_i;

    ////////////////////
    // Random source
    ////////////////////

    function automatic logic random_bit();
        lfsr_state = {lfsr_state[14:0], lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^
                      lfsr_state[10]}; // Taps 16 14 13 11
        return lfsr_state[0];
    endfunction

    function automatic logic [ctrl_pkg::REG_SIZE-1:0] random_reg();
        logic [ctrl_pkg::REG_SIZE-1:0] r;
        r = '0;
        r[0] = random_bit();
        r[1] = random_bit(); // Only r0 to r3 so hazards are frequent
        return r;
    endfunction

    // High with a chance of one in 2**n
    function automatic logic rare_event(input int n);
        logic any;
        any = 1'b0;
        for (int i = 0; i < n; i++) any = any | random_bit();
        return !any;
    endfunction

    ////////////////////
    // Reference model
    ////////////////////

    function automatic logic writes_reg(input logic [ctrl_pkg::REG_SIZE-1:0] r);
        for (int s = 0; s < 3; s++) if (m_valid[s] && m_we[s] && m_dst[s] == r) return 1'b1;
        return 1'b0;
    endfunction

    function automatic logic [15:0] expected_outputs();
        logic hazard, dc_miss, ic_miss, blk_mem, blk_id, sel, req;
        hazard  = valid_id_i && ((rd_src_a_id_i && writes_reg(src_a_id_i)) ||
                                 (rd_src_b_id_i && writes_reg(src_b_id_i)));
        dc_miss = m_valid[1] && m_ma[1] && !dc_hit_i;
        ic_miss = !ic_hit_i;
        blk_mem = dc_miss || store_buffer_draining_i;
        blk_id  = blk_mem || hazard;
        req     = (m_arb != ctrl_pkg::ARB_IDLE) || ic_miss || dc_miss;
        sel     = (m_arb == ctrl_pkg::ARB_DC) ||
                  (m_arb == ctrl_pkg::ARB_IDLE && !ic_miss && dc_miss);
        return {blk_id || ic_miss || m_fin, blk_id, blk_mem, blk_mem,
                (ic_miss && !blk_id) || m_fin, hazard || tkbr_i, blk_mem,
                m_prev_if, m_prev_mem, tkbr_i, m_fin && m_fin_age >= ctrl_pkg::FINISH_DELAY,
                sel, req, m_valid[0], m_valid[1], m_valid[2]};
    endfunction

    // Moves the model to the state after the coming rising edge
    task automatic advance_model();
        logic [15:0] e;
        logic dc_miss;
        e = expected_outputs();
        dc_miss = m_valid[1] && m_ma[1] && !dc_hit_i;
        if (reset_i) begin
            m_valid = '{default: 1'b0};
            m_ma = '{default: 1'b0};
            m_fin = 1'b0;
            m_fin_age = 0;
            m_prev_if = 1'b0;
            m_prev_mem = 1'b0;
            m_arb = ctrl_pkg::ARB_IDLE;
        end else begin
            m_prev_if  = e[15];
            m_prev_mem = e[12];
            if (m_fin) m_fin_age++;
            else if (finish_test_i) m_fin = 1'b1;
            if (m_arb == ctrl_pkg::ARB_IDLE) begin
                if (!ic_hit_i) m_arb = ctrl_pkg::ARB_IC;
                else if (dc_miss) m_arb = ctrl_pkg::ARB_DC;
            end else if (mem_done_i) begin
                m_arb = ctrl_pkg::ARB_IDLE;
            end
            if (e[12]) begin
                m_valid[2] = 1'b0; // MEM stall leaves a bubble in WB
            end else begin
                for (int s = 2; s > 0; s--) begin
                    m_valid[s] = m_valid[s-1];
                    m_dst[s] = m_dst[s-1];
                    m_we[s] = m_we[s-1];
                    m_ma[s] = m_ma[s-1];
                end
                m_valid[0] = valid_id_i && !e[10];
                m_dst[0] = dst_id_i;
                m_we[0] = we_id_i;
                m_ma[0] = mem_access_id_i;
            end
        end
    endtask

    ////////////////////
    // Checking
    ////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("FAILED %s expected %0h got %0h at %0t", name, expected, actual, $time);
            error_count++;
        end
    endtask

    always @(negedge clk_i) begin : compare_outputs
        logic [15:0] exp_v;
        logic [15:0] act_v;
        if (!reset_i) begin
            exp_v = expected_outputs();
            act_v = {block_if_o, block_id_o, block_ex_o, block_mem_o, inject_nops_id_o,
                     inject_nops_ex_o, inject_nops_wb_o, blocked_1cycle_ago_if_o,
                     blocked_1cycle_ago_mem_o, tkbr_o, finish_test_o, sel_mem_req_o,
                     mem_req_o, valid_ex_o, valid_mem_o, valid_wb_o};
            for (int i = 0; i < 16; i++) check_value(out_names[i], exp_v[15-i], act_v[15-i]);
        end
        advance_model();
    end

    initial begin : watchdog
        #((5 + random_cycles + directed_cycles) * 4 * 2);
        $display("Timeout, the tests did not complete in the expected time");
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic drive_id(input logic v, input logic [ctrl_pkg::REG_SIZE-1:0] sa,
                            input logic [ctrl_pkg::REG_SIZE-1:0] sb, input logic ra,
                            input logic rb, input logic [ctrl_pkg::REG_SIZE-1:0] d,
                            input logic we, input logic ma);
        valid_id_i      <= v;
        src_a_id_i      <= sa;
        src_b_id_i      <= sb;
        rd_src_a_id_i   <= ra;
        rd_src_b_id_i   <= rb;
        dst_id_i        <= d;
        we_id_i         <= we;
        mem_access_id_i <= ma;
    endtask

    // Empties the pipeline and ends any grant in flight
    task automatic settle_pipeline();
        @(posedge clk_i);
        drive_id(0, 0, 0, 0, 0, 0, 0, 0);
        {tkbr_i, store_buffer_draining_i, finish_test_i} <= 3'b000;
        ic_hit_i   <= 1'b1;
        dc_hit_i   <= 1'b1;
        mem_done_i <= 1'b1;
        @(posedge clk_i);
        mem_done_i <= 1'b0;
        repeat (3) @(posedge clk_i);
    endtask

    task automatic report_test(input string name);
        @(negedge clk_i);
        #1;
        $display("%-12s %0d errors", name, error_count - test_start_errors);
        test_start_errors = error_count;
        tests_run++;
    endtask

    initial begin
        clk_i = 1'b0;
        reset_i = 1'b1;
        {valid_id_i, rd_src_a_id_i, rd_src_b_id_i, we_id_i, mem_access_id_i} = '0;
        {src_a_id_i, src_b_id_i, dst_id_i} = '0;
        {finish_test_i, tkbr_i, store_buffer_draining_i, mem_done_i} = '0;
        ic_hit_i = 1'b1;
        dc_hit_i = 1'b1;
        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;

        @(negedge clk_i);
        check_value("sel_mem_req_o", ctrl_pkg::MEM_OWNER_IC, sel_mem_req_o);
        check_value("mem_req_o", 0, mem_req_o);
        report_test("reset");

        // Writer of r3, then a reader held until the writer leaves WB
        settle_pipeline();
        drive_id(1, 0, 0, 0, 0, 3, 1, 0);
        @(posedge clk_i);
        drive_id(1, 3, 1, 1, 0, 1, 0, 0);
        stall_cycles = 0;
        @(negedge clk_i);
        while (block_id_o && stall_cycles < 10) begin
            stall_cycles++;
            @(negedge clk_i);
        end
        check_value("block_id_o cycles", 3, stall_cycles);
        @(posedge clk_i);
        drive_id(1, 0, 0, 0, 0, 5, 1, 0);
        @(posedge clk_i);
        drive_id(1, 5, 5, 0, 0, 6, 0, 0); // Reads nothing
        @(posedge clk_i);
        drive_id(1, 6, 6, 1, 1, 2, 0, 0); // Producer of r6 does not write
        @(negedge clk_i);
        check_value("block_id_o", 0, block_id_o);
        report_test("hazards");

        settle_pipeline();
        drive_id(1, 2, 2, 0, 0, 1, 1, 0);
        tkbr_i <= 1'b1;
        @(negedge clk_i);
        check_value("inject_nops_ex_o", 1, inject_nops_ex_o);
        check_value("block_id_o", 0, block_id_o);
        @(posedge clk_i);
        tkbr_i <= 1'b0;
        drive_id(0, 0, 0, 0, 0, 0, 0, 0);
        @(negedge clk_i);
        check_value("valid_ex_o", 0, valid_ex_o);
        report_test("branch");

        // Load reaches MEM two edges later and misses
        settle_pipeline();
        drive_id(1, 0, 0, 0, 0, 4, 0, 1);
        @(posedge clk_i);
        drive_id(0, 0, 0, 0, 0, 0, 0, 0);
        @(posedge clk_i);
        dc_hit_i <= 1'b0;
        @(negedge clk_i);
        check_value("block_if_o", 1, block_if_o);
        check_value("inject_nops_wb_o", 1, inject_nops_wb_o);
        @(negedge clk_i);
        check_value("blocked_1cycle_ago_mem_o", 1, blocked_1cycle_ago_mem_o);
        @(posedge clk_i);
        dc_hit_i <= 1'b1;
        store_buffer_draining_i <= 1'b1;
        @(posedge clk_i);
        store_buffer_draining_i <= 1'b0;
        @(negedge clk_i);
        check_value("blocked_1cycle_ago_mem_o", 1, blocked_1cycle_ago_mem_o);
        report_test("mem_stall");

        settle_pipeline();
        drive_id(1, 0, 0, 0, 0, 4, 0, 1);
        @(posedge clk_i);
        drive_id(0, 0, 0, 0, 0, 0, 0, 0);
        @(posedge clk_i);
        dc_hit_i <= 1'b0;
        ic_hit_i <= 1'b0; // Both miss together
        @(negedge clk_i);
        check_value("sel_mem_req_o", ctrl_pkg::MEM_OWNER_IC, sel_mem_req_o);
        @(posedge clk_i);
        ic_hit_i <= 1'b1; // Load keeps missing under the IC grant
        @(negedge clk_i);
        check_value("sel_mem_req_o", ctrl_pkg::MEM_OWNER_IC, sel_mem_req_o);
        repeat (2) @(posedge clk_i);
        mem_done_i <= 1'b1;
        @(posedge clk_i);
        mem_done_i <= 1'b0;
        @(negedge clk_i);
        check_value("sel_mem_req_o", ctrl_pkg::MEM_OWNER_DC, sel_mem_req_o);
        @(posedge clk_i);
        dc_hit_i <= 1'b1;
        mem_done_i <= 1'b1;
        @(posedge clk_i);
        mem_done_i <= 1'b0;
        ic_hit_i <= 1'b0;
        @(negedge clk_i);
        check_value("inject_nops_id_o", 1, inject_nops_id_o);
        report_test("arbitration");

        settle_pipeline();
        repeat (random_cycles) begin
            @(posedge clk_i);
            drive_id(random_bit(), random_reg(), random_reg(), random_bit(), random_bit(),
                     random_reg(), random_bit(), random_bit());
            tkbr_i <= rare_event(3);
            ic_hit_i <= !rare_event(3);
            dc_hit_i <= !rare_event(2);
            store_buffer_draining_i <= rare_event(4);
            mem_done_i <= rare_event(2);
        end
        report_test("random");

        // Finish is sticky so it runs last
        settle_pipeline();
        finish_test_i <= 1'b1;
        @(posedge clk_i);
        finish_test_i <= 1'b0;
        stall_cycles = 0;
        @(negedge clk_i);
        check_value("inject_nops_id_o", 1, inject_nops_id_o);
        while (!finish_test_o && stall_cycles < 10) begin
            @(posedge clk_i);
            stall_cycles++;
            @(negedge clk_i);
        end
        check_value("finish_test_o delay", ctrl_pkg::FINISH_DELAY, stall_cycles);
        repeat (4) @(posedge clk_i);
        report_test("finish");

        $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : pipeline_control_tb

// ==== filelist.f ====
src/ctrl_pkg.sv
src/hazard_detector.sv
src/stage_tracker.sv
src/stall_unit.sv
src/mem_arbiter.sv
src/pipeline_control.sv
bench/pipeline_control_tb.sv

// ==== src/ctrl_pkg.sv ====
package ctrl_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    localparam int REG_SIZE     = 5;  // Register identifier width
    localparam int WORD_SIZE    = 32; // Machine word and main memory address width
    localparam int FINISH_DELAY = 3;  // Latched finish to finish_test_o

    ////////////////////
    // Arbiter encodings
    ////////////////////

    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0, // No refill in flight
        ARB_IC   = 2'd1, // Instruction cache owns the port
        ARB_DC   = 2'd2  // Data cache owns the port
    } arb_state_e;

    // Drives the address and data muxes in front of main memory
    typedef enum logic {
        MEM_OWNER_IC = 1'b0,
        MEM_OWNER_DC = 1'b1
    } mem_owner_e;

endpackage : ctrl_pkg

// ==== src/hazard_detector.sv ====
`timescale 1ns/1ps

module hazard_detector (
    // ID instruction sources
    input  logic                         valid_id_i,
    input  logic [ctrl_pkg::REG_SIZE-1:0] src_a_id_i,
    input  logic [ctrl_pkg::REG_SIZE-1:0] src_b_id_i,
    input  logic                         rd_src_a_id_i,
    input  logic                         rd_src_b_id_i,

    // EX destination
    input  logic                         valid_ex_i,
    input  logic [ctrl_pkg::REG_SIZE-1:0] dst_ex_i,
    input  logic                         we_ex_i,

    // MEM destination
    input  logic                         valid_mem_i,
    input  logic [ctrl_pkg::REG_SIZE-1:0] dst_mem_i,
    input  logic                         we_mem_i,

    // WB destination
    input  logic                         valid_wb_i,
    input  logic [ctrl_pkg::REG_SIZE-1:0] dst_wb_i,
    input  logic                         we_wb_i,

    output logic                         data_hazard_o
);

    // Stage produces a register value somebody may still need
    logic wr_ex;
    logic wr_mem;
    logic wr_wb;

    logic dep_a_ex;
    logic dep_a_mem;
    logic dep_a_wb;
    logic dep_b_ex;
    logic dep_b_mem;
    logic dep_b_wb;

    assign wr_ex  = valid_ex_i && we_ex_i;
    assign wr_mem = valid_mem_i && we_mem_i;
    assign wr_wb  = valid_wb_i && we_wb_i;

    // No special case for x0
    assign dep_a_ex  = rd_src_a_id_i && wr_ex  && (src_a_id_i == dst_ex_i);
    assign dep_a_mem = rd_src_a_id_i && wr_mem && (src_a_id_i == dst_mem_i);
    assign dep_a_wb  = rd_src_a_id_i && wr_wb  && (src_a_id_i == dst_wb_i);

    assign dep_b_ex  = rd_src_b_id_i && wr_ex  && (src_b_id_i == dst_ex_i);
    assign dep_b_mem = rd_src_b_id_i && wr_mem && (src_b_id_i == dst_mem_i);
    assign dep_b_wb  = rd_src_b_id_i && wr_wb  && (src_b_id_i == dst_wb_i);

    assign data_hazard_o = valid_id_i && (dep_a_ex || dep_a_mem || dep_a_wb ||
                                          dep_b_ex || dep_b_mem || dep_b_wb);

endmodule : hazard_detector

// ==== src/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                 clk_i,
    input  logic                 reset_i,

    input  logic                 ic_hit_i,
    input  logic                 dc_hit_i,
    input  logic                 valid_mem_i,
    input  logic                 mem_access_mem_i,
    input  logic                 mem_done_i,      // End of refill pulse

    output ctrl_pkg::mem_owner_e sel_mem_req_o,
    output logic                 mem_req_o
);

    ctrl_pkg::arb_state_e state_q;
    ctrl_pkg::arb_state_e state_d;

    logic ic_miss;
    logic dc_miss;

    assign ic_miss = !ic_hit_i;
    assign dc_miss = valid_mem_i && mem_access_mem_i && !dc_hit_i;

    ////////////////////
    // Grant FSM
    ////////////////////

    always_comb begin
        state_d       = state_q;
        sel_mem_req_o = ctrl_pkg::MEM_OWNER_IC; // Default mux setting
        mem_req_o     = 1'b0;

        unique case (state_q)
            ctrl_pkg::ARB_IDLE: begin
                // Grant starts right away with IC first
                if (ic_miss) begin
                    mem_req_o = 1'b1;
                    state_d   = ctrl_pkg::ARB_IC;
                end else if (dc_miss) begin
                    sel_mem_req_o = ctrl_pkg::MEM_OWNER_DC;
                    mem_req_o     = 1'b1;
                    state_d       = ctrl_pkg::ARB_DC;
                end
            end
            ctrl_pkg::ARB_IC: begin
                mem_req_o = 1'b1;
                if (mem_done_i) state_d = ctrl_pkg::ARB_IDLE;
            end
            ctrl_pkg::ARB_DC: begin
                sel_mem_req_o = ctrl_pkg::MEM_OWNER_DC;
                mem_req_o     = 1'b1;
                if (mem_done_i) state_d = ctrl_pkg::ARB_IDLE;
            end
            default: begin
                state_d = ctrl_pkg::ARB_IDLE;
            end
        endcase
    end

    // Holds the grant since the caches drop the request once served
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ctrl_pkg::ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule : mem_arbiter

// ==== src/pipeline_control.sv ====
`timescale 1ns/1ps

module pipeline_control (
    input  logic                         clk_i,
    input  logic                         reset_i,

    input  logic                         finish_test_i,

    // IF
    input  logic                         ic_hit_i,

    // ID instruction
    input  logic                         valid_id_i,
    input  logic [ctrl_pkg::REG_SIZE-1:0] src_a_id_i,
    input  logic [ctrl_pkg::REG_SIZE-1:0] src_b_id_i,
    input  logic                         rd_src_a_id_i,
    input  logic                         rd_src_b_id_i,
    input  logic [ctrl_pkg::REG_SIZE-1:0] dst_id_i,
    input  logic                         we_id_i,
    input  logic                         mem_access_id_i,

    // EX
    input  logic                         tkbr_i,

    // MEM
    input  logic                         dc_hit_i,
    input  logic                         store_buffer_draining_i,

    // Main memory
    input  logic                         mem_done_i,

    output logic                         block_if_o,
    output logic                         block_id_o,
    output logic                         block_ex_o,
    output logic                         block_mem_o,
    output logic                         inject_nops_id_o,
    output logic                         inject_nops_ex_o,
    output logic                         inject_nops_wb_o,
    output logic                         blocked_1cycle_ago_if_o,
    output logic                         blocked_1cycle_ago_mem_o,
    output logic                         tkbr_o,
    output logic                         finish_test_o,
    output ctrl_pkg::mem_owner_e         sel_mem_req_o,
    output logic                         mem_req_o,

    // Tracked stage occupancy
    output logic                         valid_ex_o,
    output logic                         valid_mem_o,
    output logic                         valid_wb_o
);

    logic [ctrl_pkg::REG_SIZE-1:0] dst_ex;
    logic [ctrl_pkg::REG_SIZE-1:0] dst_mem;
    logic [ctrl_pkg::REG_SIZE-1:0] dst_wb;
    logic                         we_ex;
    logic                         we_mem;
    logic                         we_wb;
    logic                         mem_access_mem;
    logic                         data_hazard;

    stage_tracker u_stage_tracker (
        .clk_i, .reset_i,
        .valid_id_i, .dst_id_i, .we_id_i, .mem_access_id_i,
        .block_mem_i      (block_mem_o),
        .inject_nops_ex_i (inject_nops_ex_o),
        .valid_ex_o,  .dst_ex_o (dst_ex),  .we_ex_o (we_ex),
        .valid_mem_o, .dst_mem_o (dst_mem), .we_mem_o (we_mem),
        .mem_access_mem_o (mem_access_mem),
        .valid_wb_o,  .dst_wb_o (dst_wb),  .we_wb_o (we_wb)
    );

    hazard_detector u_hazard_detector (
        .valid_id_i, .src_a_id_i, .src_b_id_i, .rd_src_a_id_i, .rd_src_b_id_i,
        .valid_ex_i  (valid_ex_o),  .dst_ex_i  (dst_ex),  .we_ex_i  (we_ex),
        .valid_mem_i (valid_mem_o), .dst_mem_i (dst_mem), .we_mem_i (we_mem),
        .valid_wb_i  (valid_wb_o),  .dst_wb_i  (dst_wb),  .we_wb_i  (we_wb),
        .data_hazard_o (data_hazard)
    );

    stall_unit u_stall_unit (
        .clk_i, .reset_i,
        .data_hazard_i    (data_hazard),
        .tkbr_i, .ic_hit_i, .dc_hit_i,
        .valid_mem_i      (valid_mem_o),
        .mem_access_mem_i (mem_access_mem),
        .store_buffer_draining_i, .finish_test_i,
        .block_if_o, .block_id_o, .block_ex_o, .block_mem_o,
        .inject_nops_id_o, .inject_nops_ex_o, .inject_nops_wb_o,
        .blocked_1cycle_ago_if_o, .blocked_1cycle_ago_mem_o,
        .tkbr_o, .finish_test_o
    );

    mem_arbiter u_mem_arbiter (
        .clk_i, .reset_i,
        .ic_hit_i, .dc_hit_i,
        .valid_mem_i      (valid_mem_o),
        .mem_access_mem_i (mem_access_mem),
        .mem_done_i,
        .sel_mem_req_o, .mem_req_o
    );

endmodule : pipeline_control

// ==== src/stage_tracker.sv ====
`timescale 1ns/1ps

module stage_tracker (
    input  logic                         clk_i,
    input  logic                         reset_i,

    // Instruction leaving ID
    input  logic                         valid_id_i,
    input  logic [ctrl_pkg::REG_SIZE-1:0] dst_id_i,
    input  logic                         we_id_i,
    input  logic                         mem_access_id_i,

    // Stall controls
    input  logic                         block_mem_i,
    input  logic                         inject_nops_ex_i,

    // EX stage
    output logic                         valid_ex_o,
    output logic [ctrl_pkg::REG_SIZE-1:0] dst_ex_o,
    output logic                         we_ex_o,

    // MEM stage
    output logic                         valid_mem_o,
    output logic [ctrl_pkg::REG_SIZE-1:0] dst_mem_o,
    output logic                         we_mem_o,
    output logic                         mem_access_mem_o,

    // WB stage
    output logic                         valid_wb_o,
    output logic [ctrl_pkg::REG_SIZE-1:0] dst_wb_o,
    output logic                         we_wb_o
);

    logic mem_access_ex; // Only needed to hand over to MEM

    ////////////////////
    // Valid bits
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_ex_o  <= 1'b0;
            valid_mem_o <= 1'b0;
            valid_wb_o  <= 1'b0;
        end else if (block_mem_i) begin
            valid_wb_o <= 1'b0; // EX and MEM hold while WB drains
        end else begin
            valid_wb_o  <= valid_mem_o;
            valid_mem_o <= valid_ex_o;
            valid_ex_o  <= valid_id_i && !inject_nops_ex_i; // Bubble on kill or hazard
        end
    end

    ////////////////////
    // Payload
    ////////////////////

    // A bubble only clears the valid bit so the fields just follow
    always_ff @(posedge clk_i) begin
        if (!block_mem_i) begin
            dst_wb_o         <= dst_mem_o;
            we_wb_o          <= we_mem_o;

            dst_mem_o        <= dst_ex_o;
            we_mem_o         <= we_ex_o;
            mem_access_mem_o <= mem_access_ex;

            dst_ex_o         <= dst_id_i;
            we_ex_o          <= we_id_i;
            mem_access_ex    <= mem_access_id_i;
        end
    end

endmodule : stage_tracker

// ==== src/stall_unit.sv ====
`timescale 1ns/1ps

module stall_unit (
    input  logic clk_i,
    input  logic reset_i,

    // Causes
    input  logic data_hazard_i,
    input  logic tkbr_i,
    input  logic ic_hit_i,
    input  logic dc_hit_i,
    input  logic valid_mem_i,
    input  logic mem_access_mem_i,
    input  logic store_buffer_draining_i,
    input  logic finish_test_i,

    // Per-stage control
    output logic block_if_o,
    output logic block_id_o,
    output logic block_ex_o,
    output logic block_mem_o,
    output logic inject_nops_id_o,
    output logic inject_nops_ex_o,
    output logic inject_nops_wb_o,
    output logic blocked_1cycle_ago_if_o,
    output logic blocked_1cycle_ago_mem_o,

    output logic tkbr_o,
    output logic finish_test_o
);

    logic ic_miss;
    logic dc_miss;
    logic mem_stall;

    logic                            finish_latched;
    logic [ctrl_pkg::FINISH_DELAY-1:0] finish_chain;

    assign ic_miss = !ic_hit_i;
    assign dc_miss = valid_mem_i && mem_access_mem_i && !dc_hit_i;

    ////////////////////
    // MEM stage
    ////////////////////

    assign mem_stall        = dc_miss || store_buffer_draining_i;
    assign block_mem_o      = mem_stall;
    assign inject_nops_wb_o = mem_stall; // Nothing valid leaves MEM

    ////////////////////
    // EX and ID stages
    ////////////////////

    assign block_ex_o = block_mem_o;

    // Hazard holds ID and bubbles EX
    // A taken branch bubbles EX while ID moves on and the wrong path is dropped
    assign block_id_o       = block_ex_o || data_hazard_i;
    assign inject_nops_ex_o = data_hazard_i || tkbr_i;
    assign tkbr_o           = tkbr_i;

    ////////////////////
    // IF stage
    ////////////////////

    assign block_if_o = block_id_o || ic_miss || finish_latched;

    // On a miss ID gets a bubble unless it is held anyway
    assign inject_nops_id_o = (ic_miss && !block_id_o) || finish_latched;

    ////////////////////
    // Delayed block flags
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            blocked_1cycle_ago_if_o  <= 1'b0;
            blocked_1cycle_ago_mem_o <= 1'b0;
        end else begin
            blocked_1cycle_ago_if_o  <= block_if_o;
            blocked_1cycle_ago_mem_o <= block_mem_o;
        end
    end

    ////////////////////
    // End of test
    ////////////////////

    // Sticky request that freezes fetch
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            finish_latched <= 1'b0;
        end else begin
            finish_latched <= finish_latched || finish_test_i;
        end
    end

    // Gives the pipeline time to drain before completion is reported
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            finish_chain <= '0;
        end else begin
            finish_chain <= {finish_chain[ctrl_pkg::FINISH_DELAY-2:0], finish_latched};
        end
    end

    assign finish_test_o = finish_chain[ctrl_pkg::FINISH_DELAY-1];

endmodule : stall_unit
